//--- include/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Integer register width
`define XLEN 64

// Architectural registers including x0
`define REG_NUM 32

// Issue buffer entries
// Power of two, 2 4 or 8
`define ALU_ISSUE_DP 4

// Control flags per buffer entry
// Packed as {is32w, is_usi, is_imm, is_shamt, is_auipc}
`define ALU_FLAG_W 5

`endif

//--- project.f
+incdir+include
src/alu_pkg.sv
src/alu_issue_buffer.sv
src/alu_issue.sv
src/alu_execute.sv
src/reg_wb_log.sv
src/alu_core_top.sv
sim/alu_tb_clock.sv
sim/alu_tb.sv

//--- sim/alu_tb.sv
`timescale 1ns/10ps
`include "alu_consts.svh"

module alu_tb;

	import alu_pkg::*;

	localparam int AW = $clog2(`REG_NUM);
	localparam int WAIT_LIMIT = 200;	// Cycles per wait
	localparam logic [4:0] F_W = 5'b10000;	// is32w
	localparam logic [4:0] F_U = 5'b01000;	// is_usi
	localparam logic [4:0] F_I = 5'b00100;	// is_imm
	localparam logic [4:0] F_S = 5'b00010;	// is_shamt
	localparam logic [4:0] F_A = 5'b00001;	// is_auipc

	logic             clk;
	logic             rst_n;
	logic             flush;
	logic             dispatch_valid;
	alu_fun_e         fun;
	logic             is32w;
	logic             is_usi;
	logic             is_imm;
	logic             is_shamt;
	logic             is_auipc;
	logic [AW-1:0]    rd;
	logic [AW-1:0]    rs1;
	logic [AW-1:0]    rs2;
	alu_operand_u     operand;
	logic [`XLEN-1:0] pc;
	logic             dispatch_stall;
	logic             wb_valid;
	logic [AW-1:0]    wb_rd;
	logic [`XLEN-1:0] wb_data;

	// Instruction table
	alu_fun_e         t_fun[$];
	logic [4:0]       t_flags[$];
	logic [AW-1:0]    t_rd[$];
	logic [AW-1:0]    t_rs1[$];
	logic [AW-1:0]    t_rs2[$];
	logic [`XLEN-1:0] t_operand[$];
	logic [`XLEN-1:0] t_pc[$];
	bit               t_flush[$];	// Flush before this row
	bit               t_kill[$];	// Discarded by the next flush

	// Reference model
	logic [`XLEN-1:0] mregs[`REG_NUM];
	logic [`XLEN-1:0] exp_val[`REG_NUM];
	bit               exp_pending[`REG_NUM];
	int               outstanding;

	alu_tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	alu_core_top dut (
		.CLK(clk), .rst_n(rst_n), .flush(flush),
		.dispatch_valid(dispatch_valid), .fun(fun), .is32w(is32w), .is_usi(is_usi),
		.is_imm(is_imm), .is_shamt(is_shamt), .is_auipc(is_auipc),
		.rd(rd), .rs1(rs1), .rs2(rs2), .operand(operand), .pc(pc),
		.dispatch_stall(dispatch_stall),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic add_row(input alu_fun_e f, input logic [4:0] flags, input int d,
		input int s1, input int s2, input logic [`XLEN-1:0] opnd,
		input logic [`XLEN-1:0] p, input bit fl, input bit kl);
		t_fun.push_back(f);
		t_flags.push_back(flags);
		t_rd.push_back(AW'(d));
		t_rs1.push_back(AW'(s1));
		t_rs2.push_back(AW'(s2));
		t_operand.push_back(opnd);
		t_pc.push_back(p);
		t_flush.push_back(fl);
		t_kill.push_back(kl);
	endtask

	// ==========================================================================
	// Program-order reference
	// ==========================================================================

	function automatic logic [`XLEN-1:0] model_result(input int r);
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] full;
		logic [31:0]      a32;
		logic [31:0]      r32;
		logic [5:0]       sh;
		logic             w, u, im, sa, ap;
		{w, u, im, sa, ap} = t_flags[r];
		a = mregs[t_rs1[r]];
		if (im)
			b = t_operand[r];
		else if (sa)
			b = {{(`XLEN-6){1'b0}}, t_operand[r][5:0]};
		else
			b = mregs[t_rs2[r]];
		sh = w ? {1'b0, b[4:0]} : b[5:0];
		a32 = a[31:0];
		full = '0;
		case (t_fun[r])
			ALU_IMM: full = (ap ? t_pc[r] : '0) + t_operand[r];
			ALU_ADD: full = a + b;
			ALU_SUB: full = a - b;
			ALU_SLT: full = u ? `XLEN'(a < b) : `XLEN'($signed(a) < $signed(b));
			ALU_XOR: full = a ^ b;
			ALU_OR:  full = a | b;
			ALU_AND: full = a & b;
			ALU_SLL: full = a << sh;
			ALU_SRL: begin
				r32 = a32 >> sh;
				full = w ? {32'd0, r32} : a >> sh;
			end
			ALU_SRA: begin
				r32 = $signed(a32) >>> sh;
				full = $signed(a) >>> sh;
				if (w)
					full = {32'd0, r32};
			end
			default: full = '0;
		endcase
		if (w)
			full = {{32{full[31]}}, full[31:0]};	// Word result sign-extended
		return full;
	endfunction

	task automatic accept_row(input int r);
		logic [`XLEN-1:0] v;
		v = model_result(r);
		if (!t_kill[r]) begin
			mregs[t_rd[r]] = v;
			exp_val[t_rd[r]] = v;
			exp_pending[t_rd[r]] = 1'b1;
			outstanding++;
		end
	endtask

	task automatic wait_for_drain();
		int n;
		n = 0;
		while (outstanding != 0 && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (outstanding != 0)
			stop_on_error($sformatf("Timed out with %0d write-backs missing", outstanding));
	endtask

	// Inputs held until dispatch_stall drops
	task automatic dispatch_row(input int r);
		int   n;
		logic must_stall;
		n = 0;
		must_stall = (t_rd[r] != '0) && exp_pending[t_rd[r]];	// Older write to rd not back yet
		fun = t_fun[r];
		{is32w, is_usi, is_imm, is_shamt, is_auipc} = t_flags[r];
		rd = t_rd[r];
		rs1 = t_rs1[r];
		rs2 = t_rs2[r];
		operand.imm = t_operand[r];
		pc = t_pc[r];
		dispatch_valid = 1'b1;
		@(negedge clk);
		if (must_stall) begin
			assert (dispatch_stall === 1'b1)
			else stop_on_error($sformatf("[FAIL] dispatch_stall row %0d expected %h actual %h",
				r, 1'b1, dispatch_stall));
		end
		while (dispatch_stall && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (dispatch_stall)
			stop_on_error($sformatf("Dispatch of row %0d stalled too long", r));
		accept_row(r);
		@(posedge clk);
		#1;
		dispatch_valid = 1'b0;
	endtask

	task automatic flush_pipeline();
		dispatch_valid = 1'b0;
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	task automatic build_table();
		// lui, auipc and immediate logic
		add_row(ALU_IMM, F_I, 1, 0, 0, 64'h0000_0000_1234_5000, 64'h0, 0, 0);
		add_row(ALU_IMM, F_I | F_A, 2, 0, 0, 64'hffff_ffff_ffff_f800,
			64'h8000_0000_0000_1000, 0, 0);
		add_row(ALU_ADD, F_I, 3, 0, 0, 64'h7ff, 64'h0, 0, 0);
		add_row(ALU_ADD, F_I, 4, 1, 0, 64'hffff_ffff_ffff_ffff, 64'h0, 0, 0);
		add_row(ALU_XOR, F_I, 5, 2, 0, 64'h0f0f, 64'h0, 0, 0);
		add_row(ALU_OR,  F_I, 6, 1, 0, 64'hff, 64'h0, 0, 0);
		add_row(ALU_AND, F_I, 7, 2, 0, 64'hffff_0000_ffff_ffff, 64'h0, 0, 0);
		// Signed against unsigned compare
		add_row(ALU_IMM, F_I, 8, 0, 0, 64'hffff_ffff_8000_0000, 64'h0, 0, 0);
		add_row(ALU_SLT, 5'b0, 9, 8, 3, 64'h0, 64'h0, 0, 0);
		add_row(ALU_SLT, F_U, 10, 8, 3, 64'h0, 64'h0, 0, 0);
		// RAW chain, last row independent
		add_row(ALU_ADD, 5'b0, 11, 1, 2, 64'h0, 64'h0, 0, 0);
		add_row(ALU_SUB, 5'b0, 12, 11, 3, 64'h0, 64'h0, 0, 0);
		add_row(ALU_XOR, 5'b0, 13, 12, 4, 64'h0, 64'h0, 0, 0);
		add_row(ALU_ADD, F_I, 14, 5, 0, 64'h1, 64'h0, 0, 0);
		// Word forms and 64-bit shifts
		add_row(ALU_ADD, F_W, 15, 1, 8, 64'h0, 64'h0, 0, 0);
		add_row(ALU_SUB, F_W, 16, 3, 1, 64'h0, 64'h0, 0, 0);
		add_row(ALU_SLL, F_W | F_S, 17, 1, 0, 64'd4, 64'h0, 0, 0);
		add_row(ALU_SRL, F_W | F_S, 18, 8, 0, 64'd4, 64'h0, 0, 0);
		add_row(ALU_SRA, F_W, 19, 8, 3, 64'h0, 64'h0, 0, 0);
		add_row(ALU_SLL, F_S, 20, 1, 0, 64'd40, 64'h0, 0, 0);
		add_row(ALU_SRL, 5'b0, 21, 8, 3, 64'h0, 64'h0, 0, 0);	// Shift by 63
		add_row(ALU_SRA, F_I, 22, 2, 0, 64'd60, 64'h0, 0, 0);
		// Same rd back to back, then rd still read by a buffered row
		add_row(ALU_ADD, F_I, 23, 3, 0, 64'h1, 64'h0, 0, 0);
		add_row(ALU_ADD, F_I, 23, 23, 0, 64'h2, 64'h0, 0, 0);
		add_row(ALU_ADD, 5'b0, 24, 23, 1, 64'h0, 64'h0, 0, 0);
		add_row(ALU_IMM, F_I, 23, 0, 0, 64'h5000, 64'h0, 0, 0);
		// Two rows lost to a flush
		add_row(ALU_ADD, F_I, 20, 1, 0, 64'h100, 64'h0, 0, 1);
		add_row(ALU_ADD, 5'b0, 21, 20, 2, 64'h0, 64'h0, 0, 1);
		add_row(ALU_ADD, 5'b0, 27, 20, 21, 64'h0, 64'h0, 1, 0);
		add_row(ALU_SUB, 5'b0, 28, 27, 4, 64'h0, 64'h0, 0, 0);
	endtask

	// ==========================================================================
	// Stimulus and write-back checks
	// ==========================================================================

	initial begin
		int n;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		fun = ALU_IMM;
		{is32w, is_usi, is_imm, is_shamt, is_auipc} = 5'b0;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		operand = '0;
		pc = '0;
		outstanding = 0;
		for (int i = 0; i < `REG_NUM; i++) begin
			mregs[i] = '0;
			exp_val[i] = '0;
			exp_pending[i] = 1'b0;
		end
		build_table();
		n = 0;
		while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
			stop_on_error("Reset was never released");
		@(posedge clk);
		#1;
		for (int i = 0; i < t_fun.size(); i++) begin
			if (t_flush[i])
				flush_pipeline();
			if (t_kill[i] && (i == 0 || !t_kill[i - 1]))
				wait_for_drain();	// Empty pipeline before the lost rows
			dispatch_row(i);
		end
		wait_for_drain();
		repeat (10) @(posedge clk);	// Room for a stray write-back
		$display("Verification passed");
		$finish;
	end

	initial begin
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && wb_valid === 1'b1) begin
				assert (exp_pending[wb_rd])
				else stop_on_error($sformatf("Write-back to x%0d that no row expects", wb_rd));
				assert (wb_data === exp_val[wb_rd])
				else stop_on_error($sformatf("[FAIL] wb_data x%0d expected %h actual %h",
					wb_rd, exp_val[wb_rd], wb_data));
				exp_pending[wb_rd] = 1'b0;
				outstanding--;
			end
		end
	end

endmodule

//--- sim/alu_tb_clock.sv
`timescale 1ns/10ps

module alu_tb_clock (
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);	// Five cycles in reset
		#1 rst_n = 1'b1;
	end

endmodule

//--- src/alu_core_top.sv
`timescale 1ns/10ps
`include "alu_consts.svh"

module alu_core_top (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        flush,

	// Decoded ALU instruction
	input  logic                        dispatch_valid,
	input  alu_pkg::alu_fun_e           fun,
	input  logic                        is32w,
	input  logic                        is_usi,
	input  logic                        is_imm,
	input  logic                        is_shamt,
	input  logic                        is_auipc,
	input  logic [$clog2(`REG_NUM)-1:0] rd,
	input  logic [$clog2(`REG_NUM)-1:0] rs1,
	input  logic [$clog2(`REG_NUM)-1:0] rs2,
	input  alu_pkg::alu_operand_u       operand,
	input  logic [`XLEN-1:0]            pc,
	output logic                        dispatch_stall,

	// Result
	output logic                        wb_valid,
	output logic [$clog2(`REG_NUM)-1:0] wb_rd,
	output logic [`XLEN-1:0]            wb_data
);

	import alu_pkg::*;

	localparam int DP = `ALU_ISSUE_DP;
	localparam int AW = $clog2(`REG_NUM);

	// ==========================================================================
	// Interconnect
	// ==========================================================================

	logic [`REG_NUM-1:0]              written;
	logic                             alloc;
	logic [AW-1:0]                    alloc_rd;
	logic                             pop;
	logic [$clog2(DP)-1:0]            pop_index;
	logic [DP-1:0]                    malloc;
	logic [$bits(alu_fun_e)*DP-1:0]   buf_fun;
	logic [`ALU_FLAG_W*DP-1:0]        buf_flags;
	logic [AW*DP-1:0]                 buf_rd, buf_rs1, buf_rs2;
	logic [`XLEN*DP-1:0]              buf_operand, buf_pc;

	logic                             exe_valid;
	alu_fun_e                         exe_fun;
	logic                             exe_is32w, exe_is_usi, exe_is_imm;
	logic                             exe_is_shamt, exe_is_auipc;
	logic [AW-1:0]                    exe_rd, exe_rs1, exe_rs2;
	alu_operand_u                     exe_operand;
	logic [`XLEN-1:0]                 exe_pc;

	logic [AW-1:0]                    rs1_addr, rs2_addr;
	logic [`XLEN-1:0]                 rs1_data, rs2_data;

	// Port names match the nets above
	alu_issue_buffer u_buffer (.*);

	alu_issue u_issue (.*);

	alu_execute u_execute (.*);

	reg_wb_log u_wb_log (.*);

endmodule

//--- src/alu_execute.sv
`timescale 1ns/10ps
`include "alu_consts.svh"

module alu_execute (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        flush,

	// From issue
	input  logic                        exe_valid,
	input  alu_pkg::alu_fun_e           exe_fun,
	input  logic                        exe_is32w,
	input  logic                        exe_is_usi,
	input  logic                        exe_is_imm,
	input  logic                        exe_is_shamt,
	input  logic                        exe_is_auipc,
	input  logic [$clog2(`REG_NUM)-1:0] exe_rd,
	input  logic [$clog2(`REG_NUM)-1:0] exe_rs1,
	input  logic [$clog2(`REG_NUM)-1:0] exe_rs2,
	input  alu_pkg::alu_operand_u       exe_operand,
	input  logic [`XLEN-1:0]            exe_pc,

	// Register file read port
	output logic [$clog2(`REG_NUM)-1:0] rs1_addr,
	output logic [$clog2(`REG_NUM)-1:0] rs2_addr,
	input  logic [`XLEN-1:0]            rs1_data,
	input  logic [`XLEN-1:0]            rs2_data,

	// Write-back
	output logic                        wb_valid,
	output logic [$clog2(`REG_NUM)-1:0] wb_rd,
	output logic [`XLEN-1:0]            wb_data
);

	import alu_pkg::*;

	logic [`XLEN-1:0] op2;
	logic [5:0]       shamt;
	logic [`XLEN-1:0] src_l;	// Logical right shift source
	logic [`XLEN-1:0] src_a;	// Arithmetic right shift source
	logic [`XLEN-1:0] res;
	logic [`XLEN-1:0] res_w;

	assign rs1_addr = exe_rs1;
	assign rs2_addr = exe_rs2;

	always_comb begin
		if (exe_is_imm) begin
			op2 = exe_operand.imm;
		end else if (exe_is_shamt) begin
			op2 = `XLEN'(exe_operand.sh.shamt);
		end else begin
			op2 = rs2_data;
		end
	end

	// Word ops shift by five bits only
	assign shamt = exe_is32w ? {1'b0, op2[4:0]} : op2[5:0];
	assign src_l = exe_is32w ? {{(`XLEN-32){1'b0}}, rs1_data[31:0]} : rs1_data;
	assign src_a = exe_is32w ? {{(`XLEN-32){rs1_data[31]}}, rs1_data[31:0]} : rs1_data;

	always_comb begin
		case (exe_fun)
			ALU_IMM: res = (exe_is_auipc ? exe_pc : '0) + exe_operand.imm;
			ALU_ADD: res = rs1_data + op2;
			ALU_SUB: res = rs1_data - op2;
			ALU_SLT: res = `XLEN'(exe_is_usi ? (rs1_data < op2)
				: ($signed(rs1_data) < $signed(op2)));
			ALU_XOR: res = rs1_data ^ op2;
			ALU_OR:  res = rs1_data | op2;
			ALU_AND: res = rs1_data & op2;
			ALU_SLL: res = rs1_data << shamt;
			ALU_SRL: res = src_l >> shamt;
			ALU_SRA: res = $signed(src_a) >>> shamt;
			default: res = '0;
		endcase
	end

	assign res_w = exe_is32w ? {{(`XLEN-32){res[31]}}, res[31:0]} : res;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid & ~flush;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb_rd   <= exe_rd;
			wb_data <= res_w;
		end
	end

endmodule

//--- src/alu_issue.sv
`timescale 1ns/10ps
`include "alu_consts.svh"

module alu_issue (
	input  logic                                            CLK,
	input  logic                                            rst_n,
	input  logic                                            flush,

	// From issue buffer
	input  logic [`ALU_ISSUE_DP-1:0]                        malloc,
	input  logic [$bits(alu_pkg::alu_fun_e)*`ALU_ISSUE_DP-1:0] buf_fun,
	input  logic [`ALU_FLAG_W*`ALU_ISSUE_DP-1:0]            buf_flags,
	input  logic [$clog2(`REG_NUM)*`ALU_ISSUE_DP-1:0]       buf_rd,
	input  logic [$clog2(`REG_NUM)*`ALU_ISSUE_DP-1:0]       buf_rs1,
	input  logic [$clog2(`REG_NUM)*`ALU_ISSUE_DP-1:0]       buf_rs2,
	input  logic [`XLEN*`ALU_ISSUE_DP-1:0]                  buf_operand,
	input  logic [`XLEN*`ALU_ISSUE_DP-1:0]                  buf_pc,
	input  logic [`REG_NUM-1:0]                             written,
	output logic                                            pop,
	output logic [$clog2(`ALU_ISSUE_DP)-1:0]                pop_index,

	// Execute parameters
	output logic                                            exe_valid,
	output alu_pkg::alu_fun_e                               exe_fun,
	output logic                                            exe_is32w,
	output logic                                            exe_is_usi,
	output logic                                            exe_is_imm,
	output logic                                            exe_is_shamt,
	output logic                                            exe_is_auipc,
	output logic [$clog2(`REG_NUM)-1:0]                     exe_rd,
	output logic [$clog2(`REG_NUM)-1:0]                     exe_rs1,
	output logic [$clog2(`REG_NUM)-1:0]                     exe_rs2,
	output alu_pkg::alu_operand_u                           exe_operand,
	output logic [`XLEN-1:0]                                exe_pc
);

	import alu_pkg::*;

	localparam int DP = `ALU_ISSUE_DP;
	localparam int IW = $clog2(`ALU_ISSUE_DP);
	localparam int AW = $clog2(`REG_NUM);
	localparam int FW = $bits(alu_fun_e);

	alu_fun_e         e_fun     [DP];
	logic [AW-1:0]    e_rd      [DP];
	logic [AW-1:0]    e_rs1     [DP];
	logic [AW-1:0]    e_rs2     [DP];
	alu_operand_u     e_operand [DP];
	logic [`XLEN-1:0] e_pc      [DP];
	logic [DP-1:0]    f_32w, f_usi, f_imm, f_shamt, f_auipc;
	logic [DP-1:0]    rs1_ready, rs2_ready;
	logic [DP-1:0]    clear_raw;
	logic [IW-1:0]    sel;
	alu_operand_u     sel_operand;

	for (genvar i = 0; i < DP; i++) begin : g_entry
		assign e_fun[i]     = alu_fun_e'(buf_fun[FW*i +: FW]);
		assign e_rd[i]      = buf_rd[AW*i +: AW];
		assign e_rs1[i]     = buf_rs1[AW*i +: AW];
		assign e_rs2[i]     = buf_rs2[AW*i +: AW];
		assign e_operand[i] = buf_operand[`XLEN*i +: `XLEN];
		assign e_pc[i]      = buf_pc[`XLEN*i +: `XLEN];
		assign {f_32w[i], f_usi[i], f_imm[i], f_shamt[i], f_auipc[i]} =
			buf_flags[`ALU_FLAG_W*i +: `ALU_FLAG_W];

		// A source equal to the entry's own rd holds the old value
		// since dispatch stalls while rd has a write pending
		assign rs1_ready[i] = written[e_rs1[i]] | (e_rs1[i] == '0) | (e_rs1[i] == e_rd[i]);
		assign rs2_ready[i] = written[e_rs2[i]] | (e_rs2[i] == '0) | (e_rs2[i] == e_rd[i]);

		assign clear_raw[i] = malloc[i] & (
			(e_fun[i] == ALU_IMM)
			| ((f_imm[i] | f_shamt[i]) & rs1_ready[i])
			| (~f_imm[i] & ~f_shamt[i] & rs1_ready[i] & rs2_ready[i]));
	end

	// Lowest ready entry wins
	always_comb begin
		sel = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				sel = IW'(i);
			end
		end
	end

	assign pop       = (|clear_raw) & ~flush;
	assign pop_index = sel;

	always_comb begin
		sel_operand = '0;
		if (f_imm[sel]) begin
			sel_operand.imm = e_operand[sel].imm;
		end else if (f_shamt[sel]) begin
			sel_operand.sh.shamt = e_operand[sel].sh.shamt;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= pop;	// Already low on flush
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_fun      <= e_fun[sel];
			exe_is32w    <= f_32w[sel];
			exe_is_usi   <= f_usi[sel];
			exe_is_imm   <= f_imm[sel];
			exe_is_shamt <= f_shamt[sel];
			exe_is_auipc <= f_auipc[sel];
			exe_rd       <= e_rd[sel];
			exe_rs1      <= e_rs1[sel];
			exe_rs2      <= e_rs2[sel];
			exe_operand  <= sel_operand;
			exe_pc       <= f_auipc[sel] ? e_pc[sel] : '0;
		end
	end

	// Sources of an issued op stay written in the log while it executes
	a_src_ready: assert property (@(posedge CLK) disable iff (!rst_n || flush)
		exe_valid && exe_fun != ALU_IMM |->
			(written[exe_rs1] || exe_rs1 == '0 || exe_rs1 == exe_rd)
			&& (exe_is_imm || exe_is_shamt
				|| written[exe_rs2] || exe_rs2 == '0 || exe_rs2 == exe_rd));

endmodule

//--- src/alu_issue_buffer.sv
`timescale 1ns/10ps
`include "alu_consts.svh"

module alu_issue_buffer (
	input  logic                                            CLK,
	input  logic                                            rst_n,
	input  logic                                            flush,

	// Dispatch side
	input  logic                                            dispatch_valid,
	input  alu_pkg::alu_fun_e                               fun,
	input  logic                                            is32w,
	input  logic                                            is_usi,
	input  logic                                            is_imm,
	input  logic                                            is_shamt,
	input  logic                                            is_auipc,
	input  logic [$clog2(`REG_NUM)-1:0]                     rd,
	input  logic [$clog2(`REG_NUM)-1:0]                     rs1,
	input  logic [$clog2(`REG_NUM)-1:0]                     rs2,
	input  alu_pkg::alu_operand_u                           operand,
	input  logic [`XLEN-1:0]                                pc,
	input  logic [`REG_NUM-1:0]                             written,
	output logic                                            dispatch_stall,
	output logic                                            alloc,
	output logic [$clog2(`REG_NUM)-1:0]                     alloc_rd,

	// Issue side
	input  logic                                            pop,
	input  logic [$clog2(`ALU_ISSUE_DP)-1:0]                pop_index,
	output logic [`ALU_ISSUE_DP-1:0]                        malloc,
	output logic [$bits(alu_pkg::alu_fun_e)*`ALU_ISSUE_DP-1:0] buf_fun,
	output logic [`ALU_FLAG_W*`ALU_ISSUE_DP-1:0]            buf_flags,
	output logic [$clog2(`REG_NUM)*`ALU_ISSUE_DP-1:0]       buf_rd,
	output logic [$clog2(`REG_NUM)*`ALU_ISSUE_DP-1:0]       buf_rs1,
	output logic [$clog2(`REG_NUM)*`ALU_ISSUE_DP-1:0]       buf_rs2,
	output logic [`XLEN*`ALU_ISSUE_DP-1:0]                  buf_operand,
	output logic [`XLEN*`ALU_ISSUE_DP-1:0]                  buf_pc
);

	import alu_pkg::*;

	localparam int DP = `ALU_ISSUE_DP;
	localparam int IW = $clog2(`ALU_ISSUE_DP);
	localparam int AW = $clog2(`REG_NUM);
	localparam int FW = $bits(alu_fun_e);

	logic [IW-1:0] free_idx;
	logic          full;
	logic          rd_pending;
	logic          src_conflict;

	assign full = &malloc;

	// Lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (!malloc[i]) begin
				free_idx = IW'(i);
			end
		end
	end

	// A buffered entry still has to read the new rd
	always_comb begin
		src_conflict = 1'b0;
		for (int i = 0; i < DP; i++) begin
			if (malloc[i] && (buf_rs1[AW*i +: AW] == rd || buf_rs2[AW*i +: AW] == rd)) begin
				src_conflict = 1'b1;
			end
		end
	end

	assign rd_pending = (rd != '0) && !written[rd];	// WAW on rd
	assign dispatch_stall = flush | full | rd_pending | ((rd != '0) & src_conflict);

	assign alloc    = dispatch_valid & ~dispatch_stall;
	assign alloc_rd = rd;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			malloc <= '0;
		end else if (flush) begin
			malloc <= '0;
		end else begin
			if (pop) begin
				malloc[pop_index] <= 1'b0;
			end
			if (alloc) begin
				malloc[free_idx] <= 1'b1;	// Never the popped slot
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (alloc) begin
			buf_fun[FW*free_idx +: FW]                   <= fun;
			buf_flags[`ALU_FLAG_W*free_idx +: `ALU_FLAG_W] <= {is32w, is_usi, is_imm, is_shamt, is_auipc};
			buf_rd[AW*free_idx +: AW]                    <= rd;
			buf_rs1[AW*free_idx +: AW]                   <= rs1;
			buf_rs2[AW*free_idx +: AW]                   <= rs2;
			buf_operand[`XLEN*free_idx +: `XLEN]         <= operand;
			buf_pc[`XLEN*free_idx +: `XLEN]              <= pc;
		end
	end

	// ==========================================================================
	// Checks
	// ==========================================================================

	a_pop_valid: assert property (@(posedge CLK) disable iff (!rst_n)
		pop |-> malloc[pop_index]);

	// Occupancy never grows across a stalled cycle
	a_no_alloc_stalled: assert property (@(posedge CLK) disable iff (!rst_n)
		dispatch_stall |=> $countones(malloc) <= $countones($past(malloc)));

endmodule

//--- src/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

	// ==========================================================================
	// ALU function select
	// ==========================================================================

	typedef enum logic [3:0] {
		ALU_IMM = 4'd0,	// lui and auipc
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_SLT = 4'd3,	// Signed or unsigned by is_usi
		ALU_XOR = 4'd4,
		ALU_OR  = 4'd5,
		ALU_AND = 4'd6,
		ALU_SLL = 4'd7,
		ALU_SRL = 4'd8,
		ALU_SRA = 4'd9
	} alu_fun_e;

	// ==========================================================================
	// Second operand word
	// ==========================================================================

	// Same 64 bits read either as a full immediate
	// or as a shift amount in the low six bits
	typedef union packed {
		logic [`XLEN-1:0] imm;
		struct packed {
			logic [`XLEN-7:0] pad;	// Zero once masked by issue
			logic [5:0]       shamt;
		} sh;
	} alu_operand_u;

endpackage

//--- src/reg_wb_log.sv
`timescale 1ns/10ps
`include "alu_consts.svh"

module reg_wb_log (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        flush,
	input  logic                        alloc,
	input  logic [$clog2(`REG_NUM)-1:0] alloc_rd,
	input  logic                        wb_valid,
	input  logic [$clog2(`REG_NUM)-1:0] wb_rd,
	input  logic [`XLEN-1:0]            wb_data,
	input  logic [$clog2(`REG_NUM)-1:0] rs1_addr,
	input  logic [$clog2(`REG_NUM)-1:0] rs2_addr,
	output logic [`REG_NUM-1:0]         written,
	output logic [`XLEN-1:0]            rs1_data,
	output logic [`XLEN-1:0]            rs2_data
);

	logic [`XLEN-1:0] regs [1:`REG_NUM-1];	// x0 is hard-wired

	// A visible write-back always commits, flush or not
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			written <= '1;
		end else if (flush) begin
			written <= '1;	// Nothing left in flight
		end else begin
			if (wb_valid) begin
				written[wb_rd] <= 1'b1;
			end
			if (alloc && alloc_rd != '0) begin
				written[alloc_rd] <= 1'b0;
			end
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	// Only the dispatched owner of rd may write it back
	a_wb_pending: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid && wb_rd != '0 |-> !written[wb_rd]);

endmodule
